// File: wb_bridge_pkg.sv
package wb_bridge_pkg;

    // bus geometry.
    localparam int ADDR_W = 32;
    localparam int DATA_W = 128;
    localparam int BE_W = DATA_W / 8;

    // instruction port is 0, data port is 1.
    localparam int NUM_PORTS = 2;

    // reads always fetch the whole line.
    localparam logic [BE_W-1:0] BE_ALL = '1;

    // one line request, 177 bits.
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
    } wb_req_t;

endpackage

// File: wb_port_buf.sv
module wb_port_buf (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_req,
    input  wb_bridge_pkg::wb_req_t            i_cmd,
    output logic                              o_ack,
    output logic [wb_bridge_pkg::DATA_W-1:0]  o_rdata,
    output logic                              o_valid,
    output wb_bridge_pkg::wb_req_t            o_cmd,
    input  logic                              i_accepted,
    input  logic [wb_bridge_pkg::DATA_W-1:0]  i_rdata,
    input  logic                              i_rdata_valid
);

    import wb_bridge_pkg::*;

    wb_req_t    buf_q [2];
    logic [1:0] used_r;
    logic       wp_r;
    logic       rp_r;
    logic       ack_owed_r;
    logic       busy_reading_r;
    logic       wait_rdata_r;

    wb_req_t    in_cmd;
    logic       in_free;
    logic       pass;
    logic       push;
    logic       pop;
    logic       write_ack;

    // reads go out with every byte lane enabled.
    always_comb
    begin
        in_cmd = i_cmd;
        if (!i_cmd.write)
        begin
            in_cmd.be = BE_ALL;
        end
    end

    // request still waiting to be taken.
    assign in_free = i_req && !busy_reading_r && !ack_owed_r;

    // straight through to the arbiter when nothing is queued.
    assign pass = in_free && (used_r == 2'd0) && i_accepted;
    assign push = in_free && (used_r != 2'd2) && !((used_r == 2'd0) && i_accepted);
    assign pop = o_valid && i_accepted && (used_r != 2'd0);

    assign write_ack = in_free && i_cmd.write && (used_r == 2'd0);

    assign o_ack = write_ack || (ack_owed_r && pop) || (busy_reading_r && i_rdata_valid);
    assign o_rdata = i_rdata;

    assign o_valid = ((used_r != 2'd0) || in_free) && !wait_rdata_r;
    assign o_cmd = (used_r != 2'd0) ? buf_q[rp_r] : in_cmd;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            used_r <= 2'd0;
            wp_r <= 1'b0;
            rp_r <= 1'b0;
        end
        else
        begin
            case ({push, pop})
                2'b10: used_r <= used_r + 2'd1;
                2'b01: used_r <= used_r - 2'd1;
                default: used_r <= used_r;
            endcase
            if (push)
            begin
                wp_r <= !wp_r;
            end
            if (pop)
            begin
                rp_r <= !rp_r;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (push)
        begin
            buf_q[wp_r] <= in_cmd;
        end
    end

    // write queued behind another one, ack comes at the next pop.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            ack_owed_r <= 1'b0;
        end
        else if (push && i_cmd.write && (used_r != 2'd0))
        begin
            ack_owed_r <= 1'b1;
        end
        else if (ack_owed_r && pop)
        begin
            ack_owed_r <= 1'b0;
        end
    end

    // a taken read blocks the port until its data is back.
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy_reading_r <= 1'b0;
            wait_rdata_r <= 1'b0;
        end
        else
        begin
            if ((push || pass) && !i_cmd.write)
            begin
                busy_reading_r <= 1'b1;
            end
            else if (i_rdata_valid)
            begin
                busy_reading_r <= 1'b0;
            end

            if (o_valid && i_accepted && !o_cmd.write)
            begin
                wait_rdata_r <= 1'b1;
            end
            else if (i_rdata_valid)
            begin
                wait_rdata_r <= 1'b0;
            end
        end
    end

endmodule

// File: wb_port_arbiter.sv
module wb_port_arbiter (
    input  logic                                 i_clk,
    input  logic                                 i_rst_n,
    input  logic [wb_bridge_pkg::NUM_PORTS-1:0]  i_valid,
    input  wb_bridge_pkg::wb_req_t               i_cmd [wb_bridge_pkg::NUM_PORTS],
    output logic [wb_bridge_pkg::NUM_PORTS-1:0]  o_accepted,
    output logic [wb_bridge_pkg::NUM_PORTS-1:0]  o_rdata_valid,
    output logic [wb_bridge_pkg::DATA_W-1:0]     o_rdata,
    output logic                                 o_valid,
    output wb_bridge_pkg::wb_req_t               o_cmd,
    input  logic                                 i_accepted,
    input  logic                                 i_done,
    input  logic [wb_bridge_pkg::DATA_W-1:0]     i_rdata,
    input  logic                                 i_rdata_valid
);

    import wb_bridge_pkg::*;

    logic [NUM_PORTS-1:0] pick;
    logic [NUM_PORTS-1:0] grant_r;
    logic                 busy_r;
    logic                 take;

    // highest port index wins.
    always_comb
    begin
        pick = '0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (i_valid[p])
            begin
                pick = '0;
                pick[p] = 1'b1;
            end
        end
    end

    always_comb
    begin
        o_cmd = '0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            if (pick[p])
            begin
                o_cmd = i_cmd[p];
            end
        end
    end

    // nothing offered while a transfer is running.
    assign o_valid = !busy_r && (|i_valid);
    assign take = o_valid && i_accepted;

    assign o_accepted = pick & {NUM_PORTS{take}};

    // read data only goes back to the owner.
    assign o_rdata_valid = grant_r & {NUM_PORTS{i_rdata_valid}};
    assign o_rdata = i_rdata;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy_r <= 1'b0;
            grant_r <= '0;
        end
        else if (take)
        begin
            busy_r <= 1'b1;
            grant_r <= pick;
        end
        else if (i_done)
        begin
            busy_r <= 1'b0;
            grant_r <= '0;
        end
    end

endmodule

// File: wb_master.sv
module wb_master (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_valid,
    input  wb_bridge_pkg::wb_req_t            i_cmd,
    output logic                              o_accepted,
    output logic                              o_done,
    output logic [wb_bridge_pkg::DATA_W-1:0]  o_rdata,
    output logic                              o_rdata_valid,
    output logic                              o_wb_cyc,
    output logic                              o_wb_stb,
    output logic                              o_wb_we,
    output logic [wb_bridge_pkg::ADDR_W-1:0]  o_wb_adr,
    output logic [wb_bridge_pkg::BE_W-1:0]    o_wb_sel,
    output logic [wb_bridge_pkg::DATA_W-1:0]  o_wb_dat,
    input  logic [wb_bridge_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic                              i_wb_ack
);

    import wb_bridge_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUS
    } state_t;

    state_t            state_r;
    wb_req_t           cmd_r;
    logic [DATA_W-1:0] rdata_r;
    logic              done_r;
    logic              rdata_valid_r;
    logic              bus_end;

    assign o_accepted = (state_r == ST_IDLE) && i_valid;
    assign bus_end = (state_r == ST_BUS) && i_wb_ack;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_r <= ST_IDLE;
            done_r <= 1'b0;
            rdata_valid_r <= 1'b0;
        end
        else
        begin
            done_r <= bus_end;
            rdata_valid_r <= bus_end && !cmd_r.write;
            if (o_accepted)
            begin
                state_r <= ST_BUS;
            end
            else if (bus_end)
            begin
                state_r <= ST_IDLE;
            end
        end
    end

    // command held for the whole classic cycle.
    always_ff @(posedge i_clk)
    begin
        if (o_accepted)
        begin
            cmd_r <= i_cmd;
        end
        if (bus_end && !cmd_r.write)
        begin
            rdata_r <= i_wb_dat;
        end
    end

    assign o_wb_cyc = (state_r == ST_BUS);
    assign o_wb_stb = (state_r == ST_BUS);
    assign o_wb_we = cmd_r.write;
    assign o_wb_adr = cmd_r.addr;
    assign o_wb_sel = cmd_r.be;
    assign o_wb_dat = cmd_r.wdata;

    assign o_done = done_r;
    assign o_rdata = rdata_r;
    assign o_rdata_valid = rdata_valid_r;

endmodule

// File: wb_bridge_top.sv
module wb_bridge_top (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_p0_req,
    input  wb_bridge_pkg::wb_req_t            i_p0_cmd,
    output logic                              o_p0_ack,
    output logic [wb_bridge_pkg::DATA_W-1:0]  o_p0_rdata,
    input  logic                              i_p1_req,
    input  wb_bridge_pkg::wb_req_t            i_p1_cmd,
    output logic                              o_p1_ack,
    output logic [wb_bridge_pkg::DATA_W-1:0]  o_p1_rdata,
    output logic                              o_wb_cyc,
    output logic                              o_wb_stb,
    output logic                              o_wb_we,
    output logic [wb_bridge_pkg::ADDR_W-1:0]  o_wb_adr,
    output logic [wb_bridge_pkg::BE_W-1:0]    o_wb_sel,
    output logic [wb_bridge_pkg::DATA_W-1:0]  o_wb_dat,
    input  logic [wb_bridge_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic                              i_wb_ack
);

    import wb_bridge_pkg::*;

    logic [NUM_PORTS-1:0] buf_valid;
    wb_req_t              buf_cmd [NUM_PORTS];
    logic [NUM_PORTS-1:0] buf_accepted;
    logic [NUM_PORTS-1:0] port_rdata_valid;
    logic [DATA_W-1:0]    port_rdata;

    logic                 arb_valid;
    wb_req_t              arb_cmd;
    logic                 mst_accepted;
    logic                 mst_done;
    logic [DATA_W-1:0]    mst_rdata;
    logic                 mst_rdata_valid;

    // instruction port.
    wb_port_buf u_buf0 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req         (i_p0_req),
        .i_cmd         (i_p0_cmd),
        .o_ack         (o_p0_ack),
        .o_rdata       (o_p0_rdata),
        .o_valid       (buf_valid[0]),
        .o_cmd         (buf_cmd[0]),
        .i_accepted    (buf_accepted[0]),
        .i_rdata       (port_rdata),
        .i_rdata_valid (port_rdata_valid[0])
    );

    // data port.
    wb_port_buf u_buf1 (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_req         (i_p1_req),
        .i_cmd         (i_p1_cmd),
        .o_ack         (o_p1_ack),
        .o_rdata       (o_p1_rdata),
        .o_valid       (buf_valid[1]),
        .o_cmd         (buf_cmd[1]),
        .i_accepted    (buf_accepted[1]),
        .i_rdata       (port_rdata),
        .i_rdata_valid (port_rdata_valid[1])
    );

    wb_port_arbiter u_arb (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (buf_valid),
        .i_cmd         (buf_cmd),
        .o_accepted    (buf_accepted),
        .o_rdata_valid (port_rdata_valid),
        .o_rdata       (port_rdata),
        .o_valid       (arb_valid),
        .o_cmd         (arb_cmd),
        .i_accepted    (mst_accepted),
        .i_done        (mst_done),
        .i_rdata       (mst_rdata),
        .i_rdata_valid (mst_rdata_valid)
    );

    wb_master u_master (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_valid       (arb_valid),
        .i_cmd         (arb_cmd),
        .o_accepted    (mst_accepted),
        .o_done        (mst_done),
        .o_rdata       (mst_rdata),
        .o_rdata_valid (mst_rdata_valid),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_we       (o_wb_we),
        .o_wb_adr      (o_wb_adr),
        .o_wb_sel      (o_wb_sel),
        .o_wb_dat      (o_wb_dat),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack)
    );

endmodule

// File: wb_bridge_assertions.sv
module wb_bridge_assertions (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  logic [wb_bridge_pkg::ADDR_W-1:0]  i_wb_adr,
    input  logic [wb_bridge_pkg::BE_W-1:0]    i_wb_sel,
    input  logic [wb_bridge_pkg::DATA_W-1:0]  i_wb_dat,
    input  logic                              i_wb_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    // strobe and cycle stay up until the slave acks.
    a_held_to_ack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_stb && !i_wb_ack) |=> (i_wb_cyc && i_wb_stb))
        else $error("wishbone cycle dropped before ack");

    // request held steady while the slave waits.
    a_hold_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_stb && !i_wb_ack) |=> $stable({i_wb_we, i_wb_adr, i_wb_sel, i_wb_dat}))
        else $error("wishbone request changed before ack");

    a_cyc_ends: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wb_cyc && i_wb_ack) |=> !i_wb_cyc)
        else $error("wishbone cyc still high the cycle after ack");

endmodule

bind wb_master wb_bridge_assertions u_wb_assertions (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_wb_cyc (o_wb_cyc),
    .i_wb_stb (o_wb_stb),
    .i_wb_we  (o_wb_we),
    .i_wb_adr (o_wb_adr),
    .i_wb_sel (o_wb_sel),
    .i_wb_dat (o_wb_dat),
    .i_wb_ack (i_wb_ack)
);

// File: wb_bridge_tb.sv
module wb_bridge_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import wb_bridge_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int NUM_TESTS = 5;
    localparam int ACK_LIMIT = 200;
    localparam int MEM_DEPTH = 256;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              p0_req = 1'b0;
    wb_req_t           p0_cmd = '0;
    logic              p0_ack;
    logic [DATA_W-1:0] p0_rdata;
    logic              p1_req = 1'b0;
    wb_req_t           p1_cmd = '0;
    logic              p1_ack;
    logic [DATA_W-1:0] p1_rdata;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [ADDR_W-1:0] wb_adr;
    logic [BE_W-1:0]   wb_sel;
    logic [DATA_W-1:0] wb_dat_o;
    logic [DATA_W-1:0] wb_dat_i = '0;
    logic              wb_ack = 1'b0;

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    wb_req_t           bus_log [$];
    logic              stall = 1'b0;
    int                waits = 0;
    int                seed = 32'h0a4ddc69;
    int                errors = 0;
    int                pass_count = 0;
    int                fail_count = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    wb_bridge_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_p0_req   (p0_req),
        .i_p0_cmd   (p0_cmd),
        .o_p0_ack   (p0_ack),
        .o_p0_rdata (p0_rdata),
        .i_p1_req   (p1_req),
        .i_p1_cmd   (p1_cmd),
        .o_p1_ack   (p1_ack),
        .o_p1_rdata (p1_rdata),
        .o_wb_cyc   (wb_cyc),
        .o_wb_stb   (wb_stb),
        .o_wb_we    (wb_we),
        .o_wb_adr   (wb_adr),
        .o_wb_sel   (wb_sel),
        .o_wb_dat   (wb_dat_o),
        .i_wb_dat   (wb_dat_i),
        .i_wb_ack   (wb_ack)
    );

    initial
    begin
        for (int i = 0; i < MEM_DEPTH; i++)
        begin
            mem[i] = {32'hc0de_0000 + 32'(i), ~32'(i), 32'(i) * 32'h0101_0101,
                      32'(i) ^ 32'h5a5a_a5a5};
            ref_mem[i] = mem[i];
        end
    end

    // slave memory with 0 to 3 wait states per transfer.
    always @(posedge clk)
    begin
        wb_ack <= 1'b0;
        if (wb_cyc && wb_stb && !wb_ack && !stall)
        begin
            if (waits == 0)
            begin
                wb_ack <= 1'b1;
                bus_log.push_back({wb_we, wb_adr, wb_dat_o, wb_sel});
                for (int b = 0; b < BE_W; b++)
                begin
                    if (wb_we && wb_sel[b])
                    begin
                        mem[wb_adr[11:4]][b*8 +: 8] = wb_dat_o[b*8 +: 8];
                    end
                end
                wb_dat_i <= mem[wb_adr[11:4]];
                waits <= $unsigned($random(seed)) % 4;
            end
            else
            begin
                waits <= waits - 1;
            end
        end
    end

    function automatic wb_req_t make_cmd(logic write, logic [ADDR_W-1:0] addr,
                                         logic [DATA_W-1:0] wdata, logic [BE_W-1:0] be);
        wb_req_t c;
        c.write = write;
        c.addr = addr;
        c.wdata = wdata;
        c.be = be;
        return c;
    endfunction

    function automatic void ref_write(wb_req_t c);
        for (int b = 0; b < BE_W; b++)
        begin
            if (c.be[b])
            begin
                ref_mem[c.addr[11:4]][b*8 +: 8] = c.wdata[b*8 +: 8];
            end
        end
    endfunction

    task automatic check_req(string name, wb_req_t exp, wb_req_t act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
        if (exp !== act)
        begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic void ack_now(int cycles, string what);
        if (cycles != 1)
        begin
            $display("%s was acked after %0d cycles instead of at once", what, cycles);
            errors++;
        end
    endfunction

    function automatic void end_test(string name, int start);
        if (errors == start)
        begin
            pass_count++;
            $display("test %s: ok", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: FAILED with %0d errors", name, errors - start);
        end
    endfunction

    // cache side holds req until ack and then drops it for a cycle.
    task automatic cache_access(input int port, input wb_req_t cmd,
                                output logic [DATA_W-1:0] rdata, output int cycles);
        logic got;
        cycles = 0;
        got = 1'b0;
        @(posedge clk);
        if (port == 0)
        begin
            p0_req <= 1'b1;
            p0_cmd <= cmd;
        end
        else
        begin
            p1_req <= 1'b1;
            p1_cmd <= cmd;
        end
        while (!got && cycles < ACK_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            got = (port == 0) ? p0_ack : p1_ack;
        end
        rdata = (port == 0) ? p0_rdata : p1_rdata;
        if (!got)
        begin
            $display("port %0d request to %h was never acked", port, cmd.addr);
            errors++;
        end
        @(posedge clk);
        if (port == 0)
        begin
            p0_req <= 1'b0;
        end
        else
        begin
            p1_req <= 1'b0;
        end
    endtask

    task automatic wait_log(int n);
        int cycles;
        cycles = 0;
        while (bus_log.size() < n && cycles < ACK_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (bus_log.size() < n)
        begin
            $display("only %0d of %0d bus transfers were seen", bus_log.size(), n);
            errors++;
        end
    endtask

    task automatic test_single_write();
        int                start;
        int                cycles;
        wb_req_t           c;
        logic [DATA_W-1:0] rd;
        start = errors;
        bus_log.delete();
        c = make_cmd(1'b1, 32'h0000_0120, 128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff, BE_ALL);
        cache_access(0, c, rd, cycles);
        ack_now(cycles, "write on an idle bridge");
        ref_write(c);
        wait_log(1);
        check_req("wb write command", c, bus_log[0]);
        end_test("single write", start);
    endtask

    task automatic test_read();
        int                start;
        int                cycles;
        wb_req_t           c;
        logic [DATA_W-1:0] rd;
        start = errors;
        for (int i = 0; i < 2; i++)
        begin
            bus_log.delete();
            c = make_cmd(1'b0, (i == 0) ? 32'h0000_0120 : 32'h0000_0bd0, '0, '0);
            cache_access(1, c, rd, cycles);
            check_data("o_p1_rdata", ref_mem[c.addr[11:4]], rd);
            wait_log(1);
            check_req("wb read command", make_cmd(1'b0, c.addr, '0, BE_ALL), bus_log[0]);
        end
        end_test("read", start);
    endtask

    task automatic test_stalled_writes();
        int                start;
        int                cycles;
        logic              third_acked;
        wb_req_t           c [3];
        logic [DATA_W-1:0] rd;
        start = errors;
        third_acked = 1'b0;
        bus_log.delete();
        for (int i = 0; i < 3; i++)
        begin
            c[i] = make_cmd(1'b1, 32'h0000_0200 + 32'(i * 16), {4{32'h1000_0000 + 32'(i)}},
                            BE_ALL);
        end
        @(posedge clk);
        stall <= 1'b1;
        cache_access(0, c[0], rd, cycles);
        ack_now(cycles, "first stalled write");
        cache_access(0, c[1], rd, cycles);
        ack_now(cycles, "second stalled write");
        fork
            begin
                cache_access(0, c[2], rd, cycles);
                third_acked = 1'b1;
            end
            begin
                repeat (10) @(posedge clk);
                if (third_acked || bus_log.size() != 0)
                begin
                    $display("third write was acked or the bus moved during the stall");
                    errors++;
                end
                stall <= 1'b0;
            end
        join
        for (int i = 0; i < 3; i++)
        begin
            ref_write(c[i]);
        end
        wait_log(3);
        for (int i = 0; i < 3; i++)
        begin
            check_req("wb write command", c[i], bus_log[i]);
        end
        end_test("stalled writes", start);
    endtask

    task automatic test_partial_then_read();
        int                start;
        int                cycles;
        wb_req_t           f;
        wb_req_t           w;
        wb_req_t           r;
        logic [DATA_W-1:0] rd;
        start = errors;
        bus_log.delete();
        f = make_cmd(1'b1, 32'h0000_0570, {4{32'h5eed_0570}}, BE_ALL);
        w = make_cmd(1'b1, 32'h0000_0560, {4{32'hfeed_f00d}}, 16'h0f0f);
        r = make_cmd(1'b0, 32'h0000_0560, '0, '0);
        // busy bus keeps the partial write queued ahead of the read.
        @(posedge clk);
        stall <= 1'b1;
        cache_access(1, f, rd, cycles);
        cache_access(1, w, rd, cycles);
        stall <= 1'b0;
        ref_write(f);
        ref_write(w);
        cache_access(1, r, rd, cycles);
        check_data("o_p1_rdata", ref_mem[r.addr[11:4]], rd);
        wait_log(3);
        check_req("wb write command", f, bus_log[0]);
        check_req("wb write command", w, bus_log[1]);
        check_req("wb read command", make_cmd(1'b0, r.addr, '0, BE_ALL), bus_log[2]);
        end_test("partial write then read", start);
    endtask

    task automatic test_both_ports();
        int                start;
        int                cyc0;
        int                cyc1;
        wb_req_t           a [2];
        wb_req_t           b [2];
        wb_req_t           r;
        logic [DATA_W-1:0] rd0;
        logic [DATA_W-1:0] rd1;
        start = errors;
        bus_log.delete();
        for (int i = 0; i < 2; i++)
        begin
            a[i] = make_cmd(1'b1, 32'h0000_0800 + 32'(i * 16), {4{$random(seed)}}, 16'hffff);
            b[i] = make_cmd(1'b1, 32'h0000_0700 + 32'(i * 16), {4{$random(seed)}}, 16'h3c3c);
        end
        fork
            begin
                cache_access(0, a[0], rd0, cyc0);
                cache_access(0, a[1], rd0, cyc0);
            end
            begin
                cache_access(1, b[0], rd1, cyc1);
                cache_access(1, b[1], rd1, cyc1);
            end
        join
        for (int i = 0; i < 2; i++)
        begin
            ref_write(a[i]);
            ref_write(b[i]);
        end
        wait_log(4);
        check_req("first wb command", b[0], bus_log[0]);
        // read everything back through the instruction port.
        for (int i = 0; i < 4; i++)
        begin
            r = make_cmd(1'b0, (i < 2) ? a[i].addr : b[i-2].addr, '0, '0);
            cache_access(0, r, rd0, cyc0);
            check_data("o_p0_rdata", ref_mem[r.addr[11:4]], rd0);
        end
        end_test("both ports", start);
    endtask

    initial
    begin
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_single_write();
        test_read();
        test_stalled_writes();
        test_partial_then_read();
        test_both_ports();
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog.
    initial
    begin
        #(NUM_TESTS * 400 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d ns", NUM_TESTS * 400 * CLK_PERIOD);
        $display("sim failed");
        $finish;
    end

endmodule

// File: wb_bridge_top.f
wb_bridge_pkg.sv
wb_port_buf.sv
wb_port_arbiter.sv
wb_master.sv
wb_bridge_top.sv
wb_bridge_assertions.sv
wb_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the bridge testbench with verilator and run it.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module wb_bridge_tb \
    -f wb_bridge_top.f -o wb_bridge_sim > build.log 2>&1 \
    && ./obj_dir/wb_bridge_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
